// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f filelist.f --top-module tb_rename_stage \
		--Mdir obj_dir -o sim_rename_stage

run: compile
	./obj_dir/sim_rename_stage | tee run.log
	grep -q "All tests passed!" run.log

clean:
	rm -rf obj_dir run.log

// File: filelist.f
rename_pkg.sv
rename_table.sv
free_list.sv
rename_resolver.sv
rename_stage.sv
rename_checker.sv
tb_rename_stage.sv

// File: free_list.sv
// circular FIFO of free physical tags, grants up to two per cycle and takes one release back
`timescale 1ns/1ps
`default_nettype none

module free_list
  import rename_pkg::*;
(
  input  wire                    i_clock,
  input  wire                    i_reset,
  input  wire                    i_alloc_req [2],
  input  release_t               i_release,
  output logic                   o_grant,
  output logic [PHYS_TAG_W-1:0]  o_new_tag [2]
);

  logic [PHYS_TAG_W-1:0] queue [PHYS_REGS];
  logic [PHYS_TAG_W-1:0] head;
  logic [PHYS_TAG_W-1:0] head_plus_one;
  logic [PHYS_TAG_W-1:0] tail;
  // one extra bit so a full list of 64 fits
  logic [PHYS_TAG_W:0]   count;
  logic [1:0]            n_req;
  logic [1:0]            n_pop;

  always_comb begin
    n_req         = {1'b0, i_alloc_req[0]} + {1'b0, i_alloc_req[1]};
    o_grant       = count >= (PHYS_TAG_W + 1)'(n_req);
    n_pop         = o_grant ? n_req : 2'd0;
    head_plus_one = head + PHYS_TAG_W'(1);
    // tags leave in order, a lone slot 1 request takes the head
    o_new_tag[0]  = queue[head];
    o_new_tag[1]  = i_alloc_req[0] ? queue[head_plus_one] : queue[head];
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int t = 0; t < PHYS_REGS - FIRST_FREE_TAG; t++) begin
        queue[t] <= PHYS_TAG_W'(FIRST_FREE_TAG + t);
      end
      head  <= '0;
      tail  <= PHYS_TAG_W'(PHYS_REGS - FIRST_FREE_TAG);
      count <= (PHYS_TAG_W + 1)'(PHYS_REGS - FIRST_FREE_TAG);
    end else begin
      if (i_release.valid) begin
        queue[tail] <= i_release.tag;
        tail        <= tail + PHYS_TAG_W'(1);
      end
      head  <= head + PHYS_TAG_W'(n_pop);
      // a release this cycle becomes visible to grant next cycle
      count <= count - (PHYS_TAG_W + 1)'(n_pop) + (PHYS_TAG_W + 1)'(i_release.valid);
    end
  end

endmodule

`default_nettype wire

// File: rename_checker.sv
// testbench monitor that latches expected values per test, compares the DUT outputs and reports
`timescale 1ns/1ps
`default_nettype none

module rename_checker
  import rename_pkg::*;
(
  input  wire           i_clock,
  input  wire           i_check,
  input  wire [127:0]   i_name,
  input  instr_info_t   i_exp_info [2],
  input  wire           i_exp_panic,
  input  wire           i_exp_stall,
  input  instr_info_t   i_dut_info [2],
  input  wire           i_dut_panic,
  input  wire           i_dut_stall,
  output logic [31:0]   o_checked,
  output logic [31:0]   o_failed
);

  logic        pending;
  logic [127:0] name_q;
  instr_info_t exp_q [2];
  logic        exp_panic_q;
  logic        exp_stall_q;
  logic        dut_panic_q;
  logic        dut_stall_q;
  logic        ok;

  initial begin
    pending   = 1'b0;
    o_checked = '0;
    o_failed  = '0;
  end

  // panic and stall follow the inputs of the drive cycle, the slots show up one edge later
  always @(negedge i_clock) begin
    if (pending) begin
      ok = 1'b1;
      if (dut_panic_q !== exp_panic_q) begin
        $display("Error %0s panic expected %0b actual %0b", name_q, exp_panic_q, dut_panic_q);
        ok = 1'b0;
      end
      if (dut_stall_q !== exp_stall_q) begin
        $display("Error %0s stall expected %0b actual %0b", name_q, exp_stall_q, dut_stall_q);
        ok = 1'b0;
      end
      for (int s = 0; s < 2; s++) begin
        if (i_dut_info[s] !== exp_q[s]) begin
          $display("Error %0s slot %0d expected %h actual %h",
                   name_q, s, exp_q[s], i_dut_info[s]);
          ok = 1'b0;
        end
      end
      if (ok) begin
        $display("%0s ok", name_q);
      end else begin
        $display("%0s failed", name_q);
        o_failed = o_failed + 1;
      end
      o_checked = o_checked + 1;
      pending   = 1'b0;
    end
    // a new test can be latched in the same cycle the previous one is compared
    if (i_check) begin
      name_q      = i_name;
      exp_q[0]    = i_exp_info[0];
      exp_q[1]    = i_exp_info[1];
      exp_panic_q = i_exp_panic;
      exp_stall_q = i_exp_stall;
      dut_panic_q = i_dut_panic;
      dut_stall_q = i_dut_stall;
      pending     = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rename_input.txt
# name hold | s0: name rs1 rs2 rd wr jmp | s1: same | tag rel_v rel_tag
# expected s0: name rs1 rs2 rn tag | s1: same | panic stall   (names: 3 JAL 4 JALR 19 ADDI 28 ADD 29 SUB)
indep_pair 0 28 2 3 1 1 0 29 5 6 4 1 0 1 0 0 28 2 3 32 1 29 5 6 33 1 0 0
intra_dep 0 28 1 4 7 1 0 28 7 7 8 1 0 0 0 0 28 32 33 34 0 28 34 34 35 0 0 0
rd_zero 0 19 1 0 0 1 0 28 0 8 9 1 0 0 0 0 19 32 0 0 0 28 0 35 36 0 0 0
same_rd 0 28 9 9 10 1 0 28 1 1 10 1 0 0 0 0 28 36 36 37 0 28 32 32 38 0 0 0
map_read 0 28 10 10 11 1 0 29 7 8 12 1 0 0 0 0 28 38 38 39 0 29 34 35 40 0 0 0
jump_slot0 0 3 0 0 1 1 1 28 11 12 13 1 0 0 0 0 3 0 0 41 0 28 39 40 42 1 0 0
double_jump 1 3 0 0 0 1 1 4 1 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0
fill_a 0 28 0 0 14 1 0 28 0 0 15 1 0 0 0 0 28 0 0 43 0 28 0 0 44 0 0 0
fill_b 0 28 0 0 16 1 0 28 0 0 17 1 0 0 0 0 28 0 0 45 0 28 0 0 46 0 0 0
fill_c 0 28 0 0 18 1 0 28 0 0 19 1 0 0 0 0 28 0 0 47 0 28 0 0 48 0 0 0
fill_d 0 28 0 0 20 1 0 28 0 0 21 1 0 0 0 0 28 0 0 49 0 28 0 0 50 0 0 0
fill_e 0 28 0 0 22 1 0 28 0 0 23 1 0 0 0 0 28 0 0 51 0 28 0 0 52 0 0 0
fill_f 0 28 0 0 24 1 0 28 0 0 25 1 0 0 0 0 28 0 0 53 0 28 0 0 54 0 0 0
fill_g 0 28 0 0 26 1 0 28 0 0 27 1 0 0 0 0 28 0 0 55 0 28 0 0 56 0 0 0
fill_h 0 28 0 0 28 1 0 28 0 0 29 1 0 0 0 0 28 0 0 57 0 28 0 0 58 0 0 0
fill_i 0 28 0 0 30 1 0 28 0 0 31 1 0 0 0 0 28 0 0 59 0 28 0 0 60 0 0 0
fill_j 0 28 0 0 14 1 0 28 0 0 15 1 0 0 0 0 28 0 0 61 0 28 0 0 62 0 0 0
no_tags 0 28 0 0 2 1 0 28 0 0 3 1 0 1 1 5 0 0 0 0 0 0 0 0 0 0 0 1
release_regrant 0 28 0 0 2 1 0 28 0 0 3 1 0 1 0 0 28 0 0 63 1 28 0 0 5 1 0 0
single_slot 0 29 2 3 0 1 0 0 0 0 0 0 0 1 0 0 29 63 5 0 1 0 0 0 0 0 0 0

// File: rename_pkg.sv
// shared sizes, instruction enums and slot structs for the rename stage and its testbench
`default_nettype none

package rename_pkg;

  localparam int ARCH_REG_W     = 5;
  localparam int PHYS_TAG_W     = 6;
  localparam int PHYS_REGS      = 64;
  // tags below this one hold the reset mapping of x0..x31
  localparam int FIRST_FREE_TAG = 32;

  // UNKNOWN marks an empty slot
  typedef enum logic [5:0] {
    UNKNOWN = 6'd0,
    LUI, AUIPC, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } instr_name_t;

  typedef enum logic [2:0] {
    R, I, S, B, U, J
  } instr_type_t;

  typedef struct packed {
    logic writes;
    logic jumps;
    logic tag;
  } flags_t;

  // architectural indexes on input, physical tags on output
  typedef struct packed {
    logic [PHYS_TAG_W-1:0] rs_1;
    logic [PHYS_TAG_W-1:0] rs_2;
    logic [PHYS_TAG_W-1:0] rd;
    logic [PHYS_TAG_W-1:0] rn;
  } regs_t;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] immediate;
    instr_name_t instr_name;
    instr_type_t instr_type;
    regs_t       regs;
    flags_t      flags;
  } instr_info_t;

  typedef struct packed {
    logic [PHYS_TAG_W-1:0] rs_1;
    logic [PHYS_TAG_W-1:0] rs_2;
    logic [PHYS_TAG_W-1:0] rn;
  } query_t;

  typedef struct packed {
    logic                  valid;
    logic [PHYS_TAG_W-1:0] tag;
  } release_t;

endpackage

`default_nettype wire

// File: rename_resolver.sv
// registers the renamed pair, forwards slot 0 rd into slot 1 sources and sets speculation tags
`timescale 1ns/1ps
`default_nettype none

module rename_resolver
  import rename_pkg::*;
(
  input  wire          i_clock,
  input  wire          i_reset,
  input  instr_info_t  i_instr_info [2],
  input  query_t       i_query [2],
  input  wire          i_grant,
  input  wire          i_tag,
  output instr_info_t  o_instr_info [2],
  output logic         o_panic
);

  instr_info_t resolved [2];
  logic        valid [2];

  // slot 1 depends on slot 0 when slot 0 really produces that register
  function automatic logic match_regs(
    input logic                  writes,
    input logic [PHYS_TAG_W-1:0] rd,
    input logic [PHYS_TAG_W-1:0] rs
  );
    return writes && (rd != '0) && (rd == rs);
  endfunction

  // two jumps in one pair cannot be tagged with a single speculation bit
  always_comb begin
    o_panic = i_instr_info[0].flags.jumps && i_instr_info[1].flags.jumps;
  end

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      valid[s]              = i_instr_info[s].instr_name != UNKNOWN;
      resolved[s]           = i_instr_info[s];
      resolved[s].regs.rs_1 = i_query[s].rs_1;
      resolved[s].regs.rs_2 = i_query[s].rs_2;
      resolved[s].regs.rn   = i_query[s].rn;
    end

    // intra-pair dependency, the table has not seen slot 0's new tag yet
    if (match_regs(i_instr_info[0].flags.writes, i_instr_info[0].regs.rd,
                   i_instr_info[1].regs.rs_1)) begin
      resolved[1].regs.rs_1 = i_query[0].rn;
    end
    if (match_regs(i_instr_info[0].flags.writes, i_instr_info[0].regs.rd,
                   i_instr_info[1].regs.rs_2)) begin
      resolved[1].regs.rs_2 = i_query[0].rn;
    end

    // a jump starts the speculative region, whatever follows it gets tag 1
    resolved[0].flags.tag = i_instr_info[0].flags.jumps ? 1'b0 : i_tag;
    if (i_instr_info[1].flags.jumps) begin
      resolved[1].flags.tag = 1'b0;
    end else if (i_instr_info[0].flags.jumps) begin
      resolved[1].flags.tag = 1'b1;
    end else begin
      resolved[1].flags.tag = i_tag;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_instr_info[0] <= '0;
      o_instr_info[1] <= '0;
    end else if ((!valid[0] && !valid[1]) || !i_grant) begin
      // bubble, the source has to present the pair again
      o_instr_info[0] <= '0;
      o_instr_info[1] <= '0;
    end else if (!o_panic) begin
      for (int s = 0; s < 2; s++) begin
        o_instr_info[s] <= valid[s] ? resolved[s] : '0;
      end
    end
    // on panic the previous pair is held
  end

endmodule

`default_nettype wire

// File: rename_stage.sv
// top of the two-wide rename stage, joins alias table, free list and pair resolver
`timescale 1ns/1ps
`default_nettype none

module rename_stage
  import rename_pkg::*;
(
  input  wire          i_clock,
  input  wire          i_reset,
  input  instr_info_t  i_instr_info [2],
  input  wire          i_tag,
  input  release_t     i_release,
  output instr_info_t  o_instr_info [2],
  output logic         o_panic,
  output logic         o_stall
);

  logic                  panic;
  logic                  grant;
  logic                  alloc_req [2];
  logic [PHYS_TAG_W-1:0] new_tag [2];
  query_t                query [2];

  rename_table u_rename_table (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_instr_info (i_instr_info),
    .i_panic      (panic),
    .i_grant      (grant),
    .i_new_tag    (new_tag),
    .o_alloc_req  (alloc_req),
    .o_query      (query)
  );

  free_list u_free_list (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_alloc_req (alloc_req),
    .i_release   (i_release),
    .o_grant     (grant),
    .o_new_tag   (new_tag)
  );

  rename_resolver u_rename_resolver (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_instr_info (i_instr_info),
    .i_query      (query),
    .i_grant      (grant),
    .i_tag        (i_tag),
    .o_instr_info (o_instr_info),
    .o_panic      (panic)
  );

  assign o_panic = panic;
  // not enough free tags for this pair
  assign o_stall = !grant;

endmodule

`default_nettype wire

// File: rename_table.sv
// register alias table mapping architectural registers to physical tags, queried per slot
`timescale 1ns/1ps
`default_nettype none

module rename_table
  import rename_pkg::*;
(
  input  wire                    i_clock,
  input  wire                    i_reset,
  input  instr_info_t            i_instr_info [2],
  input  wire                    i_panic,
  input  wire                    i_grant,
  input  wire [PHYS_TAG_W-1:0]   i_new_tag [2],
  output logic                   o_alloc_req [2],
  output query_t                 o_query [2]
);

  logic [PHYS_TAG_W-1:0] map [2**ARCH_REG_W];

  // a slot needs a fresh tag only if it is live, writes and targets something other than x0
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      o_alloc_req[s] = (i_instr_info[s].instr_name != UNKNOWN) &&
                       i_instr_info[s].flags.writes &&
                       (i_instr_info[s].regs.rd != '0) &&
                       !i_panic;
    end
  end

  // source lookups see the map as it was before this pair
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      o_query[s].rs_1 = map[i_instr_info[s].regs.rs_1[ARCH_REG_W-1:0]];
      o_query[s].rs_2 = map[i_instr_info[s].regs.rs_2[ARCH_REG_W-1:0]];
      if (o_alloc_req[s] && i_grant) begin
        o_query[s].rn = i_new_tag[s];
      end else begin
        o_query[s].rn = '0;
      end
    end
  end

  // slot 1 is written last so it wins when both slots share rd
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int r = 0; r < 2**ARCH_REG_W; r++) begin
        map[r] <= PHYS_TAG_W'(r);
      end
    end else if (i_grant) begin
      for (int s = 0; s < 2; s++) begin
        if (o_alloc_req[s]) begin
          map[i_instr_info[s].regs.rd[ARCH_REG_W-1:0]] <= i_new_tag[s];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_rename_stage.sv
// testbench top for the rename stage, replays rename_input.txt with random idle gaps
`timescale 1ns/1ps
`default_nettype none

module tb_rename_stage
  import rename_pkg::*;
();

  logic        clock;
  logic        reset;
  instr_info_t instr_info [2];
  logic        tag;
  release_t    rel;
  instr_info_t dut_info [2];
  logic        dut_panic;
  logic        dut_stall;

  logic        check;
  logic [127:0] name;
  instr_info_t exp_info [2];
  logic        exp_panic;
  logic        exp_stall;
  logic [31:0] checked;
  logic [31:0] failed;

  rename_stage dut (
    .i_clock      (clock),
    .i_reset      (reset),
    .i_instr_info (instr_info),
    .i_tag        (tag),
    .i_release    (rel),
    .o_instr_info (dut_info),
    .o_panic      (dut_panic),
    .o_stall      (dut_stall)
  );

  rename_checker u_checker (
    .i_clock     (clock),
    .i_check     (check),
    .i_name      (name),
    .i_exp_info  (exp_info),
    .i_exp_panic (exp_panic),
    .i_exp_stall (exp_stall),
    .i_dut_info  (dut_info),
    .i_dut_panic (dut_panic),
    .i_dut_stall (dut_stall),
    .o_checked   (checked),
    .o_failed    (failed)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic instr_info_t make_slot(input int nm, input int rs_1, input int rs_2,
                                            input int rd, input int wr, input int jmp,
                                            input int idx, input int s);
    instr_info_t info;
    info                 = '0;
    info.address         = 32'h1000 + 32'(idx * 8 + s * 4);
    info.immediate       = 32'(idx);
    info.instr_name      = instr_name_t'(nm[5:0]);
    info.instr_type      = (jmp != 0) ? J : R;
    info.regs.rs_1       = rs_1[PHYS_TAG_W-1:0];
    info.regs.rs_2       = rs_2[PHYS_TAG_W-1:0];
    info.regs.rd         = rd[PHYS_TAG_W-1:0];
    info.flags.writes    = wr[0];
    info.flags.jumps     = jmp[0];
    return info;
  endfunction

  // renamed slot keeps everything but the physical sources, new tag and speculation bit
  function automatic instr_info_t expect_slot(input instr_info_t in, input int nm,
                                              input int rs_1, input int rs_2,
                                              input int rn, input int spec);
    instr_info_t e;
    e = in;
    e.regs.rs_1  = rs_1[PHYS_TAG_W-1:0];
    e.regs.rs_2  = rs_2[PHYS_TAG_W-1:0];
    e.regs.rn    = rn[PHYS_TAG_W-1:0];
    e.flags.tag  = spec[0];
    if (nm == 0) begin
      e = '0;
    end
    return e;
  endfunction

  task automatic drive_idle();
    instr_info[0] = '0;
    instr_info[1] = '0;
    tag           = 1'b0;
    rel           = '0;
    check         = 1'b0;
  endtask

  initial begin
    int          fd;
    int          code;
    int          n;
    int          idle;
    int          issued;
    int          idx;
    int          bad_lines;
    int          timeout;
    int          v [28];
    logic [31:0] seed;
    string       line;
    instr_info_t prev_exp [2];

    drive_idle();
    name      = '0;
    exp_info[0] = '0;
    exp_info[1] = '0;
    exp_panic = 1'b0;
    exp_stall = 1'b0;
    prev_exp[0] = '0;
    prev_exp[1] = '0;
    seed      = 32'd35266;
    issued    = 0;
    idx       = 0;
    bad_lines = 0;
    reset     = 1'b1;
    repeat (4) @(posedge clock);
    #2;

    // a live pair in the last reset cycle still leaves empty slots
    name          = "after_reset";
    instr_info[0] = make_slot(28, 2, 3, 1, 1, 0, 0, 0);
    instr_info[1] = make_slot(29, 5, 6, 4, 1, 0, 0, 1);
    tag           = 1'b1;
    check         = 1'b1;
    issued++;
    @(posedge clock);
    #2;
    reset = 1'b0;
    drive_idle();

    fd = $fopen("rename_input.txt", "r");
    if (fd == 0) begin
      $display("could not open rename_input.txt");
      bad_lines++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 2 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d",
                      name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                      v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                      v[19], v[20], v[21], v[22], v[23], v[24], v[25], v[26], v[27]);
          if (n != 29) begin
            $display("stimulus line has %0d fields instead of 29", n);
            bad_lines++;
          end else begin
            // a held pair must follow its predecessor directly
            seed = next_rand(seed);
            idle = (v[0] != 0) ? 0 : int'(seed[17:16]) % 3;
            repeat (idle) begin
              @(posedge clock);
              #2;
              drive_idle();
            end
            @(posedge clock);
            #2;
            idx++;
            instr_info[0] = make_slot(v[1], v[2], v[3], v[4], v[5], v[6], idx, 0);
            instr_info[1] = make_slot(v[7], v[8], v[9], v[10], v[11], v[12], idx, 1);
            tag           = v[13][0];
            rel.valid     = v[14][0];
            rel.tag       = v[15][PHYS_TAG_W-1:0];
            if (v[0] != 0) begin
              exp_info[0] = prev_exp[0];
              exp_info[1] = prev_exp[1];
            end else begin
              exp_info[0] = expect_slot(instr_info[0], v[16], v[17], v[18], v[19], v[20]);
              exp_info[1] = expect_slot(instr_info[1], v[21], v[22], v[23], v[24], v[25]);
            end
            prev_exp[0] = exp_info[0];
            prev_exp[1] = exp_info[1];
            exp_panic   = v[26][0];
            exp_stall   = v[27][0];
            check       = 1'b1;
            issued++;
          end
        end
      end
      $fclose(fd);
    end

    @(posedge clock);
    #2;
    drive_idle();
    timeout = 0;
    while (checked < 32'(issued) && timeout < 50) begin
      @(posedge clock);
      timeout++;
    end

    if (checked < 32'(issued)) begin
      $display("checker finished only %0d of %0d tests before the timeout", checked, issued);
      $display("Test failures found");
    end else begin
      $display("%0d tests checked, %0d failed, %0d bad stimulus lines",
               checked, failed, bad_lines);
      if (failed == 0 && bad_lines == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
